// File: logic/gpio_pkg.sv
package gpio_pkg;

  // ----------------------------------------------------------
  // Pin side
  // ----------------------------------------------------------

  // Number of general purpose pins handled by the peripheral
  localparam int unsigned GPIO_COUNT = 16;

  // Flops in each input synchronizer chain
  localparam int unsigned SYNC_STAGES = 2;

  // ----------------------------------------------------------
  // Bus side
  // ----------------------------------------------------------

  // Byte address width, registers sit on word boundaries
  localparam int unsigned ADDR_W = 5;

  // Bus data width, bits above GPIO_COUNT read as zero
  localparam int unsigned DATA_W = 32;

  // Byte offset bits inside one data word
  localparam int unsigned ADDR_LSB = $clog2(DATA_W / 8);

  // Word offset bits used to select a register
  localparam int unsigned REG_IDX_W = ADDR_W - ADDR_LSB;

  // Register word offsets
  // Byte address is offset times four
  // A byte address that is not word aligned counts as unmapped
  typedef enum logic [REG_IDX_W-1:0] {
    // Pin enable
    REG_EN,
    // Direction, 1 = output
    REG_DIR,
    // Output value
    REG_OUT,
    // Masked input view, read only
    REG_IN,
    // Toggle request, write only pulse, reads zero
    REG_TOGGLE,
    // Interrupt enable
    REG_INTR_EN,
    // Edge select, 1 = rising, 0 = falling
    REG_INTR_EDGE,
    // Sticky status, write 1 to clear
    REG_INTR_STATUS
  } gpio_reg_e;

endpackage

// File: logic/gpio_hw_if.sv
`timescale 1ns/100ps

interface gpio_hw_if
  import gpio_pkg::*;
();

  // Configuration from the register file to the pin logic
  logic [GPIO_COUNT-1:0] en;
  logic [GPIO_COUNT-1:0] dir;
  logic [GPIO_COUNT-1:0] out;
  // One cycle toggle request per pin
  logic [GPIO_COUNT-1:0] toggle;
  logic [GPIO_COUNT-1:0] intr_en;
  logic [GPIO_COUNT-1:0] intr_edge;

  // Status from the pin logic back to the register file
  // Synchronized input already masked by the input condition
  logic [GPIO_COUNT-1:0] sync_in;
  // New OUT value, only meaningful where out_valid is set
  logic [GPIO_COUNT-1:0] out_next;
  logic [GPIO_COUNT-1:0] out_valid;
  // Qualified edge, one pulse per edge
  logic [GPIO_COUNT-1:0] intr;

  // Register file side
  modport reg_mp (
    output en, dir, out, toggle, intr_en, intr_edge,
    input  sync_in, out_next, out_valid, intr
  );

  // Pin logic side
  modport hw_mp (
    input  en, dir, out, toggle, intr_en, intr_edge,
    output sync_in, out_next, out_valid, intr
  );

endinterface

// File: logic/gpio_sync.sv
`timescale 1ns/100ps

module gpio_sync
  import gpio_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  // Asynchronous pin level
  input  logic serial_i,
  // Synchronized level, SYNC_STAGES edges after serial_i
  output logic sync_o,
  // Synchronized level one edge older
  output logic delayed_o
);

  // Shift chain, bit 0 samples the pin
  logic [SYNC_STAGES-1:0] sync_q;
  // Previous synchronized value for edge detection
  logic                   delayed_q;

  // ----------------------------------------------------------
  // Synchronizer chain and delay flop
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q    <= '0;
      delayed_q <= 1'b0;
    end else begin
      // Shift toward the MSB, new sample enters at bit 0
      sync_q    <= {sync_q[SYNC_STAGES-2:0], serial_i};
      delayed_q <= sync_q[SYNC_STAGES-1];
    end
  end

  // Last stage of the chain is the synchronized level
  assign sync_o    = sync_q[SYNC_STAGES-1];
  assign delayed_o = delayed_q;

endmodule

// File: logic/gpio_reg_file.sv
`timescale 1ns/100ps

module gpio_reg_file
  import gpio_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  // Request side of the bus
  input  logic              bus_req_i,
  input  logic              bus_we_i,
  input  logic [ADDR_W-1:0] bus_addr_i,
  input  logic [DATA_W-1:0] bus_wdata_i,
  // Response side of the bus
  output logic              bus_gnt_o,
  output logic              bus_rvalid_o,
  output logic [DATA_W-1:0] bus_rdata_o,
  // Configuration out, pin status in
  gpio_hw_if.reg_mp         hw
);

  // Register storage
  logic [GPIO_COUNT-1:0] en_q;
  logic [GPIO_COUNT-1:0] dir_q;
  logic [GPIO_COUNT-1:0] out_q;
  logic [GPIO_COUNT-1:0] toggle_q;
  logic [GPIO_COUNT-1:0] intr_en_q;
  logic [GPIO_COUNT-1:0] intr_edge_q;
  logic [GPIO_COUNT-1:0] intr_status_q;

  // Decode
  gpio_reg_e             reg_sel;
  logic                  addr_aligned;
  logic                  wr_en;
  logic                  rd_en;
  logic [GPIO_COUNT-1:0] wdata_pins;

  // Response
  logic [GPIO_COUNT-1:0] rdata_pins;
  logic                  rvalid_q;
  logic [DATA_W-1:0]     rdata_q;

  // ----------------------------------------------------------
  // Bus decode
  // ----------------------------------------------------------

  // Grant is immediate, no back-pressure
  assign bus_gnt_o = bus_req_i;

  // Word offset picks the register
  assign reg_sel      = gpio_reg_e'(bus_addr_i[ADDR_W-1:ADDR_LSB]);
  assign addr_aligned = (bus_addr_i[ADDR_LSB-1:0] == '0);

  // Misaligned accesses act as unmapped
  assign wr_en = bus_req_i & bus_we_i & addr_aligned;
  assign rd_en = bus_req_i & ~bus_we_i & addr_aligned;

  // Only the low pin bits of write data are stored
  assign wdata_pins = bus_wdata_i[GPIO_COUNT-1:0];

  // ----------------------------------------------------------
  // Register storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q          <= '0;
      dir_q         <= '0;
      out_q         <= '0;
      toggle_q      <= '0;
      intr_en_q     <= '0;
      intr_edge_q   <= '0;
      intr_status_q <= '0;
    end else begin
      // Toggle lasts one cycle unless rewritten
      toggle_q <= '0;

      // Pin logic updates to OUT, a bus write below overrides
      out_q <= (out_q & ~hw.out_valid) | (hw.out_next & hw.out_valid);

      // New edges set status, clearing happens below
      intr_status_q <= intr_status_q | hw.intr;

      if (wr_en) begin
        unique case (reg_sel)
          REG_EN:          en_q        <= wdata_pins;
          REG_DIR:         dir_q       <= wdata_pins;
          REG_OUT:         out_q       <= wdata_pins;
          REG_TOGGLE:      toggle_q    <= wdata_pins;
          REG_INTR_EN:     intr_en_q   <= wdata_pins;
          REG_INTR_EDGE:   intr_edge_q <= wdata_pins;
          // Write one clears, a set in the same cycle wins
          REG_INTR_STATUS: intr_status_q <= (intr_status_q & ~wdata_pins) | hw.intr;
          // IN is read only
          default:         ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------

  // Read mux, zero for writes and unmapped offsets
  always_comb begin
    rdata_pins = '0;
    if (rd_en) begin
      unique case (reg_sel)
        REG_EN:          rdata_pins = en_q;
        REG_DIR:         rdata_pins = dir_q;
        REG_OUT:         rdata_pins = out_q;
        REG_IN:          rdata_pins = hw.sync_in;
        REG_INTR_EN:     rdata_pins = intr_en_q;
        REG_INTR_EDGE:   rdata_pins = intr_edge_q;
        REG_INTR_STATUS: rdata_pins = intr_status_q;
        // TOGGLE is write only
        default:         rdata_pins = '0;
      endcase
    end
  end

  // Response one cycle after the accepted request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= bus_req_i;
      // Upper bits zero extended
      rdata_q  <= DATA_W'(rdata_pins);
    end
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rdata_q;

  // Configuration toward the pin logic
  assign hw.en        = en_q;
  assign hw.dir       = dir_q;
  assign hw.out       = out_q;
  assign hw.toggle    = toggle_q;
  assign hw.intr_en   = intr_en_q;
  assign hw.intr_edge = intr_edge_q;

endmodule

// File: logic/gpio_pin_ctrl.sv
`timescale 1ns/100ps

module gpio_pin_ctrl
  import gpio_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [GPIO_COUNT-1:0] gpio_i,
  output logic [GPIO_COUNT-1:0] gpio_o,
  output logic [GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [GPIO_COUNT-1:0] gpio_in_sync_o,
  output logic                  interrupt_o,
  gpio_hw_if.hw_mp              hw
);

  // Synchronized level and its one cycle older copy
  logic [GPIO_COUNT-1:0] sync_lvl;
  logic [GPIO_COUNT-1:0] in_sync;

  // Pin roles
  logic [GPIO_COUNT-1:0] is_input;
  logic [GPIO_COUNT-1:0] is_output;

  // Edge detection
  logic [GPIO_COUNT-1:0] rise;
  logic [GPIO_COUNT-1:0] fall;
  logic [GPIO_COUNT-1:0] pin_edge;

  // ----------------------------------------------------------
  // Input synchronizers, one per pin
  // ----------------------------------------------------------
  for (genvar idx = 0; idx < GPIO_COUNT; idx++) begin : gen_sync
    gpio_sync i_sync (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .serial_i  (gpio_i[idx]),
      .sync_o    (sync_lvl[idx]),
      .delayed_o (in_sync[idx])
    );
  end

  // Older copy is what the rest of the chip sees
  assign gpio_in_sync_o = in_sync;

  // Enabled pins are inputs with dir clear, outputs with dir set
  assign is_input  = hw.en & ~hw.dir;
  assign is_output = hw.en & hw.dir;

  // Output gating
  assign gpio_o        = hw.out & is_output;
  assign gpio_out_en_o = is_output;

  // Input view for the IN register
  assign hw.sync_in = in_sync & is_input;

  // Toggle returns inverted OUT on output pins only
  assign hw.out_valid = hw.toggle & is_output;
  assign hw.out_next  = ~hw.out & hw.out_valid;

  // ----------------------------------------------------------
  // Interrupts
  // ----------------------------------------------------------
  assign rise = sync_lvl & ~in_sync;
  assign fall = ~sync_lvl & in_sync;

  // Per pin polarity select
  assign pin_edge = (rise & hw.intr_edge) | (fall & ~hw.intr_edge);

  // Masked by enable and input role
  assign hw.intr    = pin_edge & hw.intr_en & is_input;
  assign interrupt_o = |hw.intr;

endmodule

// File: logic/gpio_top.sv
`timescale 1ns/100ps

module gpio_top
  import gpio_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Bus requests from the master
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  logic [ADDR_W-1:0]     bus_addr_i,
  input  logic [DATA_W-1:0]     bus_wdata_i,
  // Bus responses to the master
  output logic                  bus_gnt_o,
  output logic                  bus_rvalid_o,
  output logic [DATA_W-1:0]     bus_rdata_o,
  // Pin side
  input  logic [GPIO_COUNT-1:0] gpio_i,
  output logic [GPIO_COUNT-1:0] gpio_o,
  output logic [GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [GPIO_COUNT-1:0] gpio_in_sync_o,
  // One cycle pulse per qualifying edge group
  output logic                  interrupt_o
);

  // Register file to pin logic link
  gpio_hw_if hw_if ();

  // Bus decode and register storage
  gpio_reg_file i_reg_file (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .hw           (hw_if.reg_mp)
  );

  // Synchronizers, gating, toggle and interrupt logic
  gpio_pin_ctrl i_pin_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o),
    .gpio_out_en_o  (gpio_out_en_o),
    .gpio_in_sync_o (gpio_in_sync_o),
    .interrupt_o    (interrupt_o),
    .hw             (hw_if.hw_mp)
  );

endmodule

// File: verification/gpio_chk.sv
`timescale 1ns/100ps

module gpio_chk
  import gpio_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    bus_req_i,
  input  logic                    bus_gnt_i,
  input  logic                    bus_rvalid_i,
  input  logic [GPIO_COUNT-1:0]   gpio_out_i,
  input  logic [GPIO_COUNT-1:0]   gpio_out_en_i,
  // Per pin qualified edges from the pin logic
  input  logic [GPIO_COUNT-1:0]   pin_intr_i,
  // Enable, direction and interrupt configuration packed together
  input  logic [4*GPIO_COUNT-1:0] intr_cfg_i
);

  // Number of failed assertions
  int unsigned failure_count = 0;

  // ----------------------------------------------------------
  // Bus handshake
  // ----------------------------------------------------------

  // Grant is immediate
  gnt_is_req: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_gnt_i == bus_req_i)
    else begin
      $error("bus_gnt_o differs from bus_req_i");
      failure_count++;
    end

  // One response per accepted request in the following cycle
  rvalid_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_req_i |=> bus_rvalid_i)
    else begin
      $error("bus_rvalid_o missing after an accepted request");
      failure_count++;
    end

  rvalid_only_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !bus_req_i |=> !bus_rvalid_i)
    else begin
      $error("bus_rvalid_o without a request");
      failure_count++;
    end

  // ----------------------------------------------------------
  // Pin side
  // ----------------------------------------------------------

  // No output level on a pin that is not driven
  out_gated: assert property (@(posedge clk_i) disable iff (reset_i)
    (gpio_out_i & ~gpio_out_en_i) == '0)
    else begin
      $error("gpio_o high on a pin with gpio_out_en_o low");
      failure_count++;
    end

  // A selected polarity cannot repeat on the next cycle
  intr_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    $stable(intr_cfg_i) |-> ((pin_intr_i & $past(pin_intr_i)) == '0))
    else begin
      $error("interrupt pulse lasted two cycles on one pin");
      failure_count++;
    end

endmodule

bind gpio_top gpio_chk i_chk (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .bus_req_i     (bus_req_i),
  .bus_gnt_i     (bus_gnt_o),
  .bus_rvalid_i  (bus_rvalid_o),
  .gpio_out_i    (gpio_o),
  .gpio_out_en_i (gpio_out_en_o),
  .pin_intr_i    (hw_if.intr),
  .intr_cfg_i    ({hw_if.en, hw_if.dir, hw_if.intr_en, hw_if.intr_edge})
);

// File: verification/gpio_monitor.sv
`timescale 1ns/100ps

module gpio_monitor
  import gpio_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  logic [ADDR_W-1:0]     bus_addr_i,
  input  logic [DATA_W-1:0]     bus_wdata_i,
  input  logic                  bus_gnt_i,
  input  logic                  bus_rvalid_i,
  input  logic [DATA_W-1:0]     bus_rdata_i,
  input  logic [GPIO_COUNT-1:0] gpio_i,
  input  logic [GPIO_COUNT-1:0] gpio_out_i,
  input  logic [GPIO_COUNT-1:0] gpio_out_en_i,
  input  logic [GPIO_COUNT-1:0] gpio_in_sync_i,
  input  logic                  interrupt_i,
  output int unsigned           value_errors_o,
  output int unsigned           protocol_errors_o
);

  // Register model
  logic [GPIO_COUNT-1:0] en_m;
  logic [GPIO_COUNT-1:0] dir_m;
  logic [GPIO_COUNT-1:0] out_m;
  logic [GPIO_COUNT-1:0] toggle_m;
  logic [GPIO_COUNT-1:0] intr_en_m;
  logic [GPIO_COUNT-1:0] intr_edge_m;
  logic [GPIO_COUNT-1:0] status_m;
  // Sampled pins, entry 0 is the newest, the last one is the delayed copy
  logic [GPIO_COUNT-1:0] pin_hist [SYNC_STAGES+1];
  // Expected response to the previous request
  logic                  rsp_due;
  logic [DATA_W-1:0]     rsp_data;
  int unsigned           value_errors = 0;
  int unsigned           protocol_errors = 0;

  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;

  task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic protocol_error(input string what);
    protocol_errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  // ----------------------------------------------------------
  // Compare pre-edge outputs, then step the model
  // ----------------------------------------------------------
  always @(posedge clk_i) begin : model_step
    logic [GPIO_COUNT-1:0] is_in;
    logic [GPIO_COUNT-1:0] is_out;
    logic [GPIO_COUNT-1:0] qual;
    logic [GPIO_COUNT-1:0] wpins;
    logic [GPIO_COUNT-1:0] rd_pins;
    gpio_reg_e             sel;
    logic                  aligned;
    if (reset_i) begin
      en_m        = '0;
      dir_m       = '0;
      out_m       = '0;
      toggle_m    = '0;
      intr_en_m   = '0;
      intr_edge_m = '0;
      status_m    = '0;
      rsp_due     = 1'b0;
      rsp_data    = '0;
      for (int k = 0; k <= SYNC_STAGES; k++) begin
        pin_hist[k] = '0;
      end
    end else begin
      is_in  = en_m & ~dir_m;
      is_out = en_m & dir_m;
      // Edge between synchronized level and its older copy
      qual = ((pin_hist[SYNC_STAGES-1] & ~pin_hist[SYNC_STAGES] & intr_edge_m)
            | (~pin_hist[SYNC_STAGES-1] & pin_hist[SYNC_STAGES] & ~intr_edge_m))
            & intr_en_m & is_in;
      check_value("gpio_out_en_o", DATA_W'(is_out), DATA_W'(gpio_out_en_i));
      check_value("gpio_o", DATA_W'(out_m & is_out), DATA_W'(gpio_out_i));
      check_value("gpio_in_sync_o", DATA_W'(pin_hist[SYNC_STAGES]), DATA_W'(gpio_in_sync_i));
      check_value("interrupt_o", DATA_W'(|qual), DATA_W'(interrupt_i));

      // Handshake
      if (bus_gnt_i !== bus_req_i) begin
        protocol_error("bus_gnt_o does not match bus_req_i");
      end
      if (bus_rvalid_i !== rsp_due) begin
        protocol_error("bus_rvalid_o not exactly one cycle after a request");
      end else if (rsp_due) begin
        check_value("bus_rdata_o", rsp_data, bus_rdata_i);
      end

      // Decode this cycle's request
      sel     = gpio_reg_e'(bus_addr_i[ADDR_W-1:ADDR_LSB]);
      aligned = (bus_addr_i[ADDR_LSB-1:0] == '0);
      wpins   = bus_wdata_i[GPIO_COUNT-1:0];
      rd_pins = '0;
      if (bus_req_i && !bus_we_i && aligned) begin
        case (sel)
          REG_EN:          rd_pins = en_m;
          REG_DIR:         rd_pins = dir_m;
          REG_OUT:         rd_pins = out_m;
          REG_IN:          rd_pins = pin_hist[SYNC_STAGES] & is_in;
          REG_INTR_EN:     rd_pins = intr_en_m;
          REG_INTR_EDGE:   rd_pins = intr_edge_m;
          REG_INTR_STATUS: rd_pins = status_m;
          default:         rd_pins = '0;
        endcase
      end
      rsp_due  = bus_req_i;
      rsp_data = DATA_W'(rd_pins);

      // Toggle lands one edge after its write, a bus write to OUT overrides
      out_m    = out_m ^ (toggle_m & is_out);
      toggle_m = '0;
      status_m = status_m | qual;
      if (bus_req_i && bus_we_i && aligned) begin
        case (sel)
          REG_EN:          en_m        = wpins;
          REG_DIR:         dir_m       = wpins;
          REG_OUT:         out_m       = wpins;
          REG_TOGGLE:      toggle_m    = wpins;
          REG_INTR_EN:     intr_en_m   = wpins;
          REG_INTR_EDGE:   intr_edge_m = wpins;
          // Clear by ones, new edges still set
          REG_INTR_STATUS: status_m    = (status_m & ~wpins) | qual;
          default:         ;
        endcase
      end

      for (int k = SYNC_STAGES; k > 0; k--) begin
        pin_hist[k] = pin_hist[k-1];
      end
      pin_hist[0] = gpio_i;
    end
  end

endmodule

// File: verification/gpio_tb.sv
`timescale 1ns/100ps

module gpio_tb
  import gpio_pkg::*;
();

  // ----------------------------------------------------------
  // Sequence lengths and run limit
  // ----------------------------------------------------------
  localparam int unsigned RESET_CYCLES  = 4;
  localparam int unsigned REG_ROUNDS    = 40;
  localparam int unsigned PIN_ROUNDS    = 20;
  localparam int unsigned TOGGLE_ROUNDS = 20;
  localparam int unsigned INTR_ROUNDS   = 30;
  // Pin change through synchronizer and delay flop plus one spare cycle
  localparam int unsigned SETTLE_CYCLES = SYNC_STAGES + 2;
  // One cycle per bus access plus idle waits
  localparam int unsigned SEQ_CYCLES = RESET_CYCLES + 12
    + REG_ROUNDS * 5
    + PIN_ROUNDS * (3 + SETTLE_CYCLES)
    + TOGGLE_ROUNDS * 7
    + 6 + INTR_ROUNDS * (3 + SETTLE_CYCLES);
  localparam int unsigned TIMEOUT_CYCLES = 2 * SEQ_CYCLES;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  bus_req;
  logic                  bus_we;
  logic [ADDR_W-1:0]     bus_addr;
  logic [DATA_W-1:0]     bus_wdata;
  logic                  bus_gnt;
  logic                  bus_rvalid;
  logic [DATA_W-1:0]     bus_rdata;
  logic [GPIO_COUNT-1:0] gpio_in;
  logic [GPIO_COUNT-1:0] gpio_out;
  logic [GPIO_COUNT-1:0] gpio_out_en;
  logic [GPIO_COUNT-1:0] gpio_in_sync;
  logic                  interrupt;
  int unsigned           value_errors;
  int unsigned           protocol_errors;
  int unsigned           cycle_count = 0;
  logic [31:0]           lfsr_state = 32'h4110_cded;

  always #5 clk = ~clk;

  gpio_top DUT (
    .clk_i          (clk),
    .reset_i        (reset),
    .bus_req_i      (bus_req),
    .bus_we_i       (bus_we),
    .bus_addr_i     (bus_addr),
    .bus_wdata_i    (bus_wdata),
    .bus_gnt_o      (bus_gnt),
    .bus_rvalid_o   (bus_rvalid),
    .bus_rdata_o    (bus_rdata),
    .gpio_i         (gpio_in),
    .gpio_o         (gpio_out),
    .gpio_out_en_o  (gpio_out_en),
    .gpio_in_sync_o (gpio_in_sync),
    .interrupt_o    (interrupt)
  );

  gpio_monitor monitor (
    .clk_i             (clk),
    .reset_i           (reset),
    .bus_req_i         (bus_req),
    .bus_we_i          (bus_we),
    .bus_addr_i        (bus_addr),
    .bus_wdata_i       (bus_wdata),
    .bus_gnt_i         (bus_gnt),
    .bus_rvalid_i      (bus_rvalid),
    .bus_rdata_i       (bus_rdata),
    .gpio_i            (gpio_in),
    .gpio_out_i        (gpio_out),
    .gpio_out_en_i     (gpio_out_en),
    .gpio_in_sync_i    (gpio_in_sync),
    .interrupt_i       (interrupt),
    .value_errors_o    (value_errors),
    .protocol_errors_o (protocol_errors)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Fibonacci LFSR with taps from x^32 + x^22 + x^2 + x + 1
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int unsigned count);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic logic [GPIO_COUNT-1:0] random_pins();
    logic [31:0] bits;
    bits = random_bits(GPIO_COUNT);
    return bits[GPIO_COUNT-1:0];
  endfunction

  // Read-write registers only
  function automatic gpio_reg_e pick_rw_reg();
    logic [31:0] pick;
    pick = random_bits(3) % 5;
    case (pick)
      0:       return REG_EN;
      1:       return REG_DIR;
      2:       return REG_OUT;
      3:       return REG_INTR_EN;
      default: return REG_INTR_EDGE;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Bus and pin tasks start and end 1 ns after an edge
  // ----------------------------------------------------------
  task automatic bus_access(input logic is_write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
    bus_req   = 1'b1;
    bus_we    = is_write;
    bus_addr  = addr;
    bus_wdata = data;
    @(posedge clk);
    while (!bus_gnt) begin
      @(posedge clk);
    end
    #1;
    bus_req = 1'b0;
    bus_we  = 1'b0;
    while (!bus_rvalid) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_reg(input gpio_reg_e r, input logic [DATA_W-1:0] data);
    bus_access(1'b1, {r, {ADDR_LSB{1'b0}}}, data);
  endtask

  task automatic read_reg(input gpio_reg_e r);
    bus_access(1'b0, {r, {ADDR_LSB{1'b0}}}, '0);
  endtask

  // A byte offset inside a word decodes as unmapped
  task automatic read_misaligned();
    logic [ADDR_W-1:0] addr;
    addr    = ADDR_W'(random_bits(ADDR_W));
    addr[0] = 1'b1;
    bus_access(1'b0, addr, '0);
  endtask

  task automatic idle_cycles(input int unsigned count);
    repeat (count) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ----------------------------------------------------------
  // Sequences
  // ----------------------------------------------------------
  task automatic readback_after_reset();
    for (int unsigned r = 0; r < 8; r++) begin
      read_reg(gpio_reg_e'(REG_IDX_W'(r)));
    end
    read_misaligned();
  endtask

  task automatic exercise_registers();
    gpio_reg_e r;
    for (int unsigned n = 0; n < REG_ROUNDS; n++) begin
      r = pick_rw_reg();
      write_reg(r, random_bits(DATA_W));
      read_reg(r);
      read_reg(gpio_reg_e'(REG_IDX_W'(random_bits(REG_IDX_W))));
      read_misaligned();
      // IN is read only so this write is ignored
      write_reg(REG_IN, random_bits(DATA_W));
    end
  endtask

  task automatic sample_inputs();
    for (int unsigned n = 0; n < PIN_ROUNDS; n++) begin
      write_reg(REG_EN, DATA_W'(random_pins()));
      write_reg(REG_DIR, DATA_W'(random_pins()));
      gpio_in = random_pins();
      idle_cycles(SETTLE_CYCLES);
      read_reg(REG_IN);
    end
  endtask

  task automatic toggle_outputs();
    for (int unsigned n = 0; n < TOGGLE_ROUNDS; n++) begin
      write_reg(REG_EN, DATA_W'(random_pins()));
      write_reg(REG_DIR, DATA_W'(random_pins()));
      write_reg(REG_OUT, DATA_W'(random_pins()));
      write_reg(REG_TOGGLE, DATA_W'(random_pins()));
      idle_cycles(2);
      read_reg(REG_OUT);
    end
  endtask

  task automatic provoke_interrupts();
    // Mostly enabled inputs
    write_reg(REG_EN, DATA_W'(random_pins() | random_pins()));
    write_reg(REG_DIR, DATA_W'(random_pins() & random_pins()));
    write_reg(REG_INTR_EDGE, DATA_W'(random_pins()));
    write_reg(REG_INTR_EN, DATA_W'(random_pins() | random_pins()));
    write_reg(REG_INTR_STATUS, '1);
    for (int unsigned n = 0; n < INTR_ROUNDS; n++) begin
      // One transition group and then quiet until the pulse is over
      gpio_in = gpio_in ^ random_pins();
      idle_cycles(SETTLE_CYCLES);
      read_reg(REG_INTR_STATUS);
      if (n % 4 == 3) begin
        write_reg(REG_INTR_STATUS, DATA_W'(random_pins()));
        read_reg(REG_INTR_STATUS);
      end
    end
  endtask

  initial begin
    reset     = 1'b1;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    gpio_in   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    readback_after_reset();
    exercise_registers();
    sample_inputs();
    toggle_outputs();
    provoke_interrupts();
    // Let the last response reach the monitor
    idle_cycles(2);

    $display("Errors: %0d value mismatches, %0d bus protocol errors, %0d assertion failures",
             value_errors, protocol_errors, DUT.i_chk.failure_count);
    if (value_errors == 0 && protocol_errors == 0 && DUT.i_chk.failure_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
logic/gpio_pkg.sv
logic/gpio_hw_if.sv
logic/gpio_sync.sv
logic/gpio_reg_file.sv
logic/gpio_pin_ctrl.sv
logic/gpio_top.sv
verification/gpio_chk.sv
verification/gpio_monitor.sv
verification/gpio_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := gpio_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
